// ==== logic/fetch_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// 16-bit byte addresses, 64-bit blocks, memory tag 0 means no transaction
//////////////////////////////////////////////////////////////////////

package fetch_pkg;

    // address and block geometry
    localparam int ADDR_BITS       = 16;
    localparam int OFFSET_BITS     = 3;
    localparam int BLOCK_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
    localparam int BLOCK_BITS      = 64;
    localparam int MEM_TAG_BITS    = 4;

    typedef logic [ADDR_BITS-1:0]       addr_t;
    typedef logic [BLOCK_ADDR_BITS-1:0] blk_addr_t;
    typedef logic [BLOCK_BITS-1:0]      block_t;
    // zero reserved as the idle tag
    typedef logic [MEM_TAG_BITS-1:0]    mem_tag_t;

    typedef enum logic [1:0] {
        mem_none = 2'd0,
        mem_load = 2'd1
    } mem_command_t;

    // memory content rule shared by memory model and checker
    // block address on top, its inverse below
    function automatic block_t block_pattern(input blk_addr_t blk);
        logic [BLOCK_BITS/2-1:0] half;
        half = (BLOCK_BITS/2)'(blk);
        return {half, ~half};
    endfunction

endpackage

// ==== logic/cache_fill_if.sv ====
//////////////////////////////////////////////////////////////////////
// strobes are single cycle, addresses are full byte addresses
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface cache_fill_if;

    // memory accepted a load for this block
    logic               alloc_en;
    fetch_pkg::addr_t   alloc_addr;

    // returned block, written at the next edge
    logic               fill_en;
    fetch_pkg::addr_t   fill_addr;
    fetch_pkg::block_t  fill_data;

    // miss table side drives everything
    modport miss (output alloc_en, alloc_addr, fill_en, fill_addr, fill_data);

    // cache side only listens
    modport cache (input alloc_en, alloc_addr, fill_en, fill_addr, fill_data);

endinterface

// ==== logic/line_ram.sv ====
//////////////////////////////////////////////////////////////////////
// reads are combinational, a write shows on the cycle after the edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module line_ram #(
    parameter int READ_PORTS = 2,
    parameter int INDEX_BITS = 5
) (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    write_en,
    input  logic [INDEX_BITS-1:0]                   write_index,
    input  fetch_pkg::block_t                       write_data,
    input  logic [READ_PORTS-1:0][INDEX_BITS-1:0]   read_index,
    output fetch_pkg::block_t [READ_PORTS-1:0]      read_data
);

    localparam int LINES = 1 << INDEX_BITS;

    // block storage, contents undefined until filled
    fetch_pkg::block_t mem_q [LINES];

    // single write port
    always_ff @(posedge clock) begin
        if (write_en) begin
            mem_q[write_index] <= write_data;
        end
    end

    // one combinational read per window slot
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            read_data[p] = mem_q[read_index[p]];
        end
    end

    // fill strobe from the miss table must be known once out of reset
    write_en_known: assert property (
        @(posedge clock) disable iff (reset)
        !$isunknown(write_en)
    );

endmodule

// ==== logic/icache.sv ====
//////////////////////////////////////////////////////////////////////
// direct mapped, window outputs are combinational from fetch_addr
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache #(
    parameter int PREFETCH_DISTANCE = 2,
    parameter int INDEX_BITS        = 5
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  fetch_pkg::addr_t                            fetch_addr,
    cache_fill_if.cache                                 fill,
    output fetch_pkg::block_t [PREFETCH_DISTANCE-1:0]   data_out,
    output logic [PREFETCH_DISTANCE-1:0]                valid_out,
    output logic [PREFETCH_DISTANCE-1:0]                alloc_out
);

    localparam int LINES    = 1 << INDEX_BITS;
    localparam int TAG_BITS = fetch_pkg::BLOCK_ADDR_BITS - INDEX_BITS;

    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [TAG_BITS-1:0]   cache_tag_t;

    // per line state
    cache_tag_t         tag_q [LINES];
    logic [LINES-1:0]   valid_q;
    logic [LINES-1:0]   alloc_q;

    fetch_pkg::blk_addr_t                       fetch_blk;
    fetch_pkg::blk_addr_t                       win_blk [PREFETCH_DISTANCE];
    logic [PREFETCH_DISTANCE-1:0][INDEX_BITS-1:0] win_index;
    cache_tag_t                                 win_tag [PREFETCH_DISTANCE];

    fetch_pkg::blk_addr_t   alloc_blk;
    fetch_pkg::blk_addr_t   fill_blk;
    index_t                 alloc_index;
    index_t                 fill_index;
    cache_tag_t             fill_tag;

    //////////////////////////////////////////////////////////////////////
    // window lookup
    //////////////////////////////////////////////////////////////////////

    assign fetch_blk = fetch_addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::OFFSET_BITS];

    // slot i covers block address + i, so wrap past the last line is free
    always_comb begin
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            win_blk[i]   = fetch_blk + fetch_pkg::BLOCK_ADDR_BITS'(i);
            win_index[i] = win_blk[i][INDEX_BITS-1:0];
            win_tag[i]   = win_blk[i][fetch_pkg::BLOCK_ADDR_BITS-1:INDEX_BITS];
            valid_out[i] = valid_q[win_index[i]] && (tag_q[win_index[i]] == win_tag[i]);
            // alloc is per line, independent of tag
            alloc_out[i] = alloc_q[win_index[i]];
        end
    end

    line_ram #(
        .READ_PORTS (PREFETCH_DISTANCE),
        .INDEX_BITS (INDEX_BITS)
    ) u_line_ram (
        .clock       (clock),
        .reset       (reset),
        .write_en    (fill.fill_en),
        .write_index (fill_index),
        .write_data  (fill.fill_data),
        .read_index  (win_index),
        .read_data   (data_out)
    );

    //////////////////////////////////////////////////////////////////////
    // alloc and fill updates
    //////////////////////////////////////////////////////////////////////

    assign alloc_blk   = fill.alloc_addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::OFFSET_BITS];
    assign alloc_index = alloc_blk[INDEX_BITS-1:0];
    assign fill_blk    = fill.fill_addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::OFFSET_BITS];
    assign fill_index  = fill_blk[INDEX_BITS-1:0];
    assign fill_tag    = fill_blk[fetch_pkg::BLOCK_ADDR_BITS-1:INDEX_BITS];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
            alloc_q <= '0;
        end else begin
            if (fill.alloc_en) begin
                alloc_q[alloc_index] <= 1'b1;
            end
            // fill always lands with its own tag
            if (fill.fill_en) begin
                valid_q[fill_index] <= 1'b1;
                alloc_q[fill_index] <= 1'b0;
            end
        end
    end

    // tag array
    always_ff @(posedge clock) begin
        if (fill.fill_en) begin
            tag_q[fill_index] <= fill_tag;
        end
    end

    // a line with an outstanding load cannot be allocated again
    alloc_fill_disjoint: assert property (
        @(posedge clock) disable iff (reset)
        !(fill.alloc_en && fill.fill_en && (alloc_index == fill_index))
    );

endmodule

// ==== logic/fetch_mshr.sv ====
//////////////////////////////////////////////////////////////////////
// one request per cycle, holds while memory is busy or the table is full
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_mshr #(
    parameter int PREFETCH_DISTANCE = 2,
    parameter int INDEX_BITS        = 5,
    parameter int MSHR_DEPTH        = 4
) (
    input  logic                            clock,
    input  logic                            reset,
    input  fetch_pkg::addr_t                fetch_addr,
    input  logic [PREFETCH_DISTANCE-1:0]    window_valid,
    input  logic [PREFETCH_DISTANCE-1:0]    window_alloc,
    output fetch_pkg::mem_command_t         mem_command,
    output fetch_pkg::addr_t                mem_addr,
    input  fetch_pkg::mem_tag_t             mem_transaction_tag,
    input  fetch_pkg::block_t               mem_data,
    input  fetch_pkg::mem_tag_t             mem_data_tag,
    cache_fill_if.miss                      fill
);

    localparam int SLOT_BITS = (MSHR_DEPTH > 1) ? $clog2(MSHR_DEPTH) : 1;

    // entry table
    logic [MSHR_DEPTH-1:0]  ent_valid;
    fetch_pkg::mem_tag_t    ent_tag [MSHR_DEPTH];
    fetch_pkg::addr_t       ent_addr [MSHR_DEPTH];

    logic                   armed_q;
    logic                   req_found;
    fetch_pkg::blk_addr_t   req_blk;
    logic                   free_found;
    logic [SLOT_BITS-1:0]   free_slot;
    logic                   accepted;
    logic [MSHR_DEPTH-1:0]  match_vec;
    logic                   tag_live;
    logic                   line_live;

    //////////////////////////////////////////////////////////////////////
    // request stage
    //////////////////////////////////////////////////////////////////////

    // lowest slot that is neither present nor on its way
    always_comb begin
        req_found = 1'b0;
        req_blk   = fetch_addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::OFFSET_BITS];
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            if (!req_found && !window_valid[i] && !window_alloc[i]) begin
                req_found = 1'b1;
                req_blk   = fetch_addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::OFFSET_BITS]
                          + fetch_pkg::BLOCK_ADDR_BITS'(i);
            end
        end
    end

    // first empty entry
    always_comb begin
        free_found = 1'b0;
        free_slot  = '0;
        for (int e = 0; e < MSHR_DEPTH; e++) begin
            if (!free_found && !ent_valid[e]) begin
                free_found = 1'b1;
                free_slot  = SLOT_BITS'(e);
            end
        end
    end

    assign mem_command = (armed_q && req_found && free_found)
                       ? fetch_pkg::mem_load : fetch_pkg::mem_none;
    assign mem_addr    = {req_blk, fetch_pkg::OFFSET_BITS'(0)};

    // nonzero tag in the same cycle means memory took it
    assign accepted       = (mem_command == fetch_pkg::mem_load) && (mem_transaction_tag != '0);
    assign fill.alloc_en   = accepted;
    assign fill.alloc_addr = mem_addr;

    //////////////////////////////////////////////////////////////////////
    // refill stage
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        fill.fill_addr = '0;
        for (int e = 0; e < MSHR_DEPTH; e++) begin
            match_vec[e] = ent_valid[e] && (ent_tag[e] == mem_data_tag) && (mem_data_tag != '0);
            if (match_vec[e]) begin
                fill.fill_addr = fill.fill_addr | ent_addr[e];
            end
        end
    end

    assign fill.fill_en   = |match_vec;
    assign fill.fill_data = mem_data;

    // table state, requests held off for one cycle out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            ent_valid <= '0;
            armed_q   <= 1'b0;
        end else begin
            armed_q   <= 1'b1;
            ent_valid <= ent_valid & ~match_vec;
            if (accepted) begin
                ent_valid[free_slot] <= 1'b1;
            end
        end
    end

    // payload of a new entry
    always_ff @(posedge clock) begin
        if (accepted) begin
            ent_tag[free_slot]  <= mem_transaction_tag;
            ent_addr[free_slot] <= mem_addr;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // entries still waiting, ignoring those retiring now
    always_comb begin
        tag_live  = 1'b0;
        line_live = 1'b0;
        for (int e = 0; e < MSHR_DEPTH; e++) begin
            if (ent_valid[e] && !match_vec[e]) begin
                tag_live  = tag_live || (ent_tag[e] == mem_transaction_tag);
                line_live = line_live || (ent_addr[e][fetch_pkg::OFFSET_BITS +: INDEX_BITS]
                                         == req_blk[INDEX_BITS-1:0]);
            end
        end
    end

    one_data_match: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(match_vec)
    );

    // memory never reuses a tag before its data came back
    fresh_tag: assert property (
        @(posedge clock) disable iff (reset)
        accepted |-> !tag_live
    );

    // alloc bit in the cache keeps a second load off a busy line
    one_load_per_line: assert property (
        @(posedge clock) disable iff (reset)
        (mem_command == fetch_pkg::mem_load) |-> !line_live
    );

endmodule

// ==== logic/icache_fetch_top.sv ====
//////////////////////////////////////////////////////////////////////
// memory must follow the tagged protocol, tag 0 reads as busy or idle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_fetch_top #(
    parameter int PREFETCH_DISTANCE = 2,
    parameter int INDEX_BITS        = 5,
    parameter int MSHR_DEPTH        = 4
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  fetch_pkg::addr_t                            fetch_addr,
    output fetch_pkg::block_t [PREFETCH_DISTANCE-1:0]   data_out,
    output logic [PREFETCH_DISTANCE-1:0]                valid_out,
    output logic [PREFETCH_DISTANCE-1:0]                alloc_out,
    output fetch_pkg::mem_command_t                     mem_command,
    output fetch_pkg::addr_t                            mem_addr,
    input  fetch_pkg::mem_tag_t                         mem_transaction_tag,
    input  fetch_pkg::block_t                           mem_data,
    input  fetch_pkg::mem_tag_t                         mem_data_tag
);

    // alloc and fill strobes back into the cache
    cache_fill_if fill_bus ();

    icache #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .INDEX_BITS        (INDEX_BITS)
    ) u_icache (
        .clock      (clock),
        .reset      (reset),
        .fetch_addr (fetch_addr),
        .fill       (fill_bus),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .alloc_out  (alloc_out)
    );

    // window state closes the loop into the miss table
    fetch_mshr #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .INDEX_BITS        (INDEX_BITS),
        .MSHR_DEPTH        (MSHR_DEPTH)
    ) u_fetch_mshr (
        .clock               (clock),
        .reset               (reset),
        .fetch_addr          (fetch_addr),
        .window_valid        (valid_out),
        .window_alloc        (alloc_out),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .fill                (fill_bus)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
//////////////////////////////////////////////////////////////////////
// fixed latency tagged memory, a tag is never reused while in flight
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_mem_model #(
    parameter int LATENCY = 6
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [7:0]              busy_percent,
    input  fetch_pkg::mem_command_t mem_command,
    input  fetch_pkg::addr_t        mem_addr,
    output fetch_pkg::mem_tag_t     mem_transaction_tag,
    output fetch_pkg::block_t       mem_data,
    output fetch_pkg::mem_tag_t     mem_data_tag,
    output int                      accept_count,
    output int                      max_outstanding
);

    localparam int TAGS = 1 << fetch_pkg::MEM_TAG_BITS;

    // delay line of accepted loads
    fetch_pkg::mem_tag_t    pipe_tag [LATENCY];
    fetch_pkg::blk_addr_t   pipe_blk [LATENCY];
    logic [TAGS-1:0]        live_q;
    logic [TAGS-1:0]        live_next;
    logic                   busy_q;
    fetch_pkg::mem_tag_t    free_tag;
    int                     live_count;

    // lowest tag not in flight, 0 when all are taken
    always_comb begin
        free_tag   = '0;
        live_count = 0;
        for (int t = TAGS - 1; t > 0; t--) begin
            if (!live_q[t]) begin
                free_tag = fetch_pkg::mem_tag_t'(t);
            end
        end
        for (int t = 0; t < TAGS; t++) begin
            if (live_q[t]) begin
                live_count++;
            end
        end
    end

    assign mem_transaction_tag = (!reset && !busy_q && (mem_command == fetch_pkg::mem_load))
                               ? free_tag : '0;
    assign mem_data_tag        = reset ? '0 : pipe_tag[LATENCY-1];
    assign mem_data            = fetch_pkg::block_pattern(pipe_blk[LATENCY-1]);

    // retire the returning tag, mark the new one
    always_comb begin
        live_next = live_q;
        if (pipe_tag[LATENCY-1] != '0) begin
            live_next[pipe_tag[LATENCY-1]] = 1'b0;
        end
        if (mem_transaction_tag != '0) begin
            live_next[mem_transaction_tag] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q          <= 1'b0;
            live_q          <= '0;
            accept_count    <= 0;
            max_outstanding <= 0;
            for (int s = 0; s < LATENCY; s++) begin
                pipe_tag[s] <= '0;
                pipe_blk[s] <= '0;
            end
        end else begin
            // busy for the whole next cycle
            busy_q      <= ($urandom % 32'd100) < 32'(busy_percent);
            pipe_tag[0] <= mem_transaction_tag;
            pipe_blk[0] <= mem_addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::OFFSET_BITS];
            for (int s = 1; s < LATENCY; s++) begin
                pipe_tag[s] <= pipe_tag[s-1];
                pipe_blk[s] <= pipe_blk[s-1];
            end
            live_q <= live_next;
            if (mem_transaction_tag != '0) begin
                accept_count <= accept_count + 1;
            end
            if (live_count > max_outstanding) begin
                max_outstanding <= live_count;
            end
        end
    end

endmodule

// ==== sim/icache_fetch_tb.sv ====
//////////////////////////////////////////////////////////////////////
// runs from the project root and reads sim/icache_testdata.txt
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module icache_fetch_tb;

    localparam int PREFETCH_DISTANCE = 2;
    localparam int INDEX_BITS        = 5;
    // one entry keeps the second window load waiting for a free slot
    localparam int MSHR_DEPTH        = 1;
    localparam int LATENCY           = 6;
    localparam int RESET_CYCLES      = 8;
    localparam int MAX_WORDS         = 64;
    localparam int CYCLES_PER_OP     = 200;
    localparam int LINES             = 1 << INDEX_BITS;

    // op codes in the top digit of a data word
    localparam logic [3:0] OP_END  = 4'h0;
    localparam logic [3:0] OP_WAIT = 4'h1;
    localparam logic [3:0] OP_HIT  = 4'h2;

    logic                                       clock;
    logic                                       reset;
    fetch_pkg::addr_t                           fetch_addr;
    fetch_pkg::block_t [PREFETCH_DISTANCE-1:0]  data_out;
    logic [PREFETCH_DISTANCE-1:0]               valid_out;
    logic [PREFETCH_DISTANCE-1:0]               alloc_out;
    fetch_pkg::mem_command_t                    mem_command;
    fetch_pkg::addr_t                           mem_addr;
    fetch_pkg::mem_tag_t                        mem_transaction_tag;
    fetch_pkg::block_t                          mem_data;
    fetch_pkg::mem_tag_t                        mem_data_tag;
    int                                         accept_count;
    int                                         max_outstanding;

    logic [23:0]    test_words [MAX_WORDS];
    logic [7:0]     busy_percent;
    int             op_count;
    int             cycle_count = 0;
    int             cycle_limit = 0;

    // blocks the cache should hold, one per line
    fetch_pkg::blk_addr_t   resident [LINES];
    logic [LINES-1:0]       resident_valid;

    icache_fetch_top #(
        .PREFETCH_DISTANCE (PREFETCH_DISTANCE),
        .INDEX_BITS        (INDEX_BITS),
        .MSHR_DEPTH        (MSHR_DEPTH)
    ) DUT (
        .clock               (clock),
        .reset               (reset),
        .fetch_addr          (fetch_addr),
        .data_out            (data_out),
        .valid_out           (valid_out),
        .alloc_out           (alloc_out),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag)
    );

    tb_mem_model #(
        .LATENCY (LATENCY)
    ) u_mem_model (
        .clock               (clock),
        .reset               (reset),
        .busy_percent        (busy_percent),
        .mem_command         (mem_command),
        .mem_addr            (mem_addr),
        .mem_transaction_tag (mem_transaction_tag),
        .mem_data            (mem_data),
        .mem_data_tag        (mem_data_tag),
        .accept_count        (accept_count),
        .max_outstanding     (max_outstanding)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    // run limit grows with the number of operations
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: %0d cycles passed and the test list is not done", cycle_count);
            $display("TEST FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is %h, expected %h", $time, name, actual,
                     expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // memory content has the block address on top and its inverse below
    function automatic fetch_pkg::block_t expected_block(input fetch_pkg::blk_addr_t blk);
        logic [31:0] upper;
        upper = 32'(blk);
        return {upper, ~upper};
    endfunction

    // block address + i wraps in the block address width
    function automatic fetch_pkg::blk_addr_t window_block(input fetch_pkg::addr_t addr,
                                                          input int i);
        return addr[fetch_pkg::ADDR_BITS-1:fetch_pkg::OFFSET_BITS]
             + fetch_pkg::BLOCK_ADDR_BITS'(i);
    endfunction

    // lowest window block not yet held by its line
    function automatic fetch_pkg::blk_addr_t first_missing(input fetch_pkg::addr_t addr);
        fetch_pkg::blk_addr_t   blk;
        fetch_pkg::blk_addr_t   found;
        logic [INDEX_BITS-1:0]  idx;
        found = '0;
        for (int i = PREFETCH_DISTANCE - 1; i >= 0; i--) begin
            blk = window_block(addr, i);
            idx = blk[INDEX_BITS-1:0];
            if (!resident_valid[idx] || resident[idx] != blk) begin
                found = blk;
            end
        end
        return found;
    endfunction

    task automatic check_window(input fetch_pkg::addr_t addr);
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            check_value($sformatf("data_out[%0d]", i), data_out[i],
                        expected_block(window_block(addr, i)));
        end
    endtask

    // hold the address until the whole window is valid
    task automatic wait_for_window(input fetch_pkg::addr_t addr, input int loads);
        int                     start_count;
        fetch_pkg::blk_addr_t   blk;
        start_count = accept_count;
        fetch_addr  = addr;
        #1;
        check_value("window hit on first cycle", 64'(&valid_out), 64'(loads == 0));
        // miss table is empty here, so the first miss goes out at once
        if (loads != 0) begin
            check_value("mem_command", 64'(mem_command), 64'(fetch_pkg::mem_load));
            check_value("mem_addr", 64'(mem_addr),
                        64'({first_missing(addr), fetch_pkg::OFFSET_BITS'(0)}));
        end
        while (!(&valid_out)) begin
            @(negedge clock);
            #1;
        end
        check_window(addr);
        check_value("accepted loads", 64'(accept_count - start_count), 64'(loads));
        for (int i = 0; i < PREFETCH_DISTANCE; i++) begin
            blk = window_block(addr, i);
            resident[blk[INDEX_BITS-1:0]]       = blk;
            resident_valid[blk[INDEX_BITS-1:0]] = 1'b1;
        end
    endtask

    task automatic expect_hit(input fetch_pkg::addr_t addr);
        fetch_addr = addr;
        #1;
        check_value("valid_out", 64'(valid_out), 64'({PREFETCH_DISTANCE{1'b1}}));
        check_value("alloc_out", 64'(alloc_out), 64'(0));
        check_value("mem_command", 64'(mem_command), 64'(fetch_pkg::mem_none));
        check_window(addr);
    endtask

    initial begin
        logic [3:0]         op;
        logic [3:0]         loads;
        fetch_pkg::addr_t   addr;

        void'($urandom(93));
        reset          = 1'b1;
        fetch_addr     = '0;
        busy_percent   = '0;
        resident_valid = '0;
        for (int w = 0; w < MAX_WORDS; w++) begin
            test_words[w] = '0;
        end
        $readmemh("sim/icache_testdata.txt", test_words);
        busy_percent = test_words[0][7:0];
        op_count     = 0;
        while (op_count < MAX_WORDS - 1 && test_words[op_count + 1][23:20] != OP_END) begin
            op_count++;
        end
        cycle_limit = op_count * CYCLES_PER_OP + RESET_CYCLES;

        // state cleared and no load while reset is held
        repeat (RESET_CYCLES) @(negedge clock);
        check_value("valid_out", 64'(valid_out), 64'(0));
        check_value("alloc_out", 64'(alloc_out), 64'(0));
        check_value("mem_command", 64'(mem_command), 64'(fetch_pkg::mem_none));
        reset = 1'b0;
        #1;
        check_value("mem_command", 64'(mem_command), 64'(fetch_pkg::mem_none));

        for (int n = 1; n <= op_count; n++) begin
            op    = test_words[n][23:20];
            loads = test_words[n][19:16];
            addr  = test_words[n][15:0];
            @(negedge clock);
            if (op == OP_WAIT) begin
                wait_for_window(addr, int'(loads));
            end else if (op == OP_HIT) begin
                expect_hit(addr);
            end else begin
                $display("unknown operation %h in test list entry %0d", op, n);
                $display("TEST FAILED");
                $fatal(1, "bad test list");
            end
        end

        check_value("max outstanding within MSHR_DEPTH", 64'(max_outstanding <= MSHR_DEPTH),
                    64'(1));
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== sim/icache_testdata.txt ====
// first word: memory busy percent in hex
// then per line: op digit (1 wait, 2 hit), expected new loads digit, 4-digit fetch address
00001e
// cold windows and repeats
120000
200000
110008
200008
110010
200010
// same index, other tag, then the old address again
120100
200100
120000
200000
// window wraps from line 31 to line 0
1200f8
2000f8
200008
1201f8
2001f8
// spread of windows under busy cycles
120040
120050
200048
110058
120a00
200a00
// top of the address space wraps to block 0
12fff8
20fff8
110000
200000
121238
201238
200050
// end of list
000000

// ==== icache_fetch_top.f ====
logic/fetch_pkg.sv
logic/cache_fill_if.sv
logic/line_ram.sv
logic/icache.sv
logic/fetch_mshr.sv
logic/icache_fetch_top.sv
sim/tb_mem_model.sv
sim/icache_fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the icache fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module icache_fetch_tb -f icache_fetch_top.f

output=$(./obj_dir/Vicache_fetch_tb 2>&1) || true
echo "$output"

if grep -qx "TEST OK" <<< "$output"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
